// File: decodeStage.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/regFile.sv
hdl/branchResolve.sv
hdl/linkTracker.sv
hdl/decodeStage.sv
verification/clockGen.sv
verification/decodeStage_assert.sv
verification/decodeStage_tb.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStage_tb
FILELIST  ?= decodeStage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := hdl/decode_defines.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/decodeStage_trace.txt
# instr imm pcNow wbData wbAddr lbi link en bFlag jFlag halt | reg1 reg2 jmp pcSel
# Inputs and expected outputs in hex, x skips that expected column
0020 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 0
0260 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 0
04a0 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 0
06e0 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 0
0020 0000 0000 1234 1 0 0 1 0 0 0 0000 0000 0000 0
0120 0000 0000 0000 0 0 0 0 0 0 0 1234 1234 0000 0
0240 00ab 0000 ffff 2 1 0 1 0 0 0 0000 0000 x x
0240 0000 0000 0000 0 0 0 0 0 0 0 00ab 00ab 0000 0
0120 0000 0000 8001 3 0 0 1 0 0 0 1234 1234 x 0
6000 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 1
6100 0000 0000 0000 0 0 0 0 0 0 0 1234 0000 0000 0
6900 0000 0000 0000 0 0 0 0 0 0 0 1234 0000 0000 1
6800 0000 0000 0000 0 0 0 0 0 0 0 0000 0000 0000 0
7300 0000 0000 0000 0 0 0 0 0 0 0 8001 0000 0000 1
7100 0000 0000 0000 0 0 0 0 0 0 0 1234 0000 0000 0
7900 0000 0000 0000 0 0 0 0 0 0 0 1234 0000 0000 1
7b00 0000 0000 0000 0 0 0 0 0 0 0 8001 0000 0000 0
0300 0000 0000 0000 0 0 0 0 1 1 0 8001 0000 0000 1
6000 0000 0000 0000 0 0 0 0 0 0 1 0000 0000 0000 0
0000 0000 0000 0000 0 0 0 0 0 1 0 0000 0000 0000 0
3000 0000 0100 0000 0 0 0 0 0 0 0 0000 0000 0000 0
00e0 0000 0100 5555 4 0 0 1 0 0 0 0000 0102 0102 0
04e0 0000 0100 6666 4 0 0 1 0 0 0 0000 0102 0102 0
04e0 0000 0100 7777 4 0 0 1 0 0 0 0000 0102 0102 0
04e0 0000 0100 4444 4 0 0 1 0 0 0 0000 0102 0102 0
04e0 0000 0100 0000 0 0 0 0 0 0 0 4444 0102 0102 0
3800 0000 0200 0000 0 0 0 0 0 0 0 0000 0000 0102 0
00e0 0000 0200 0000 0 0 0 0 0 0 0 0000 0202 0202 0
00e0 0000 0200 0000 0 0 0 0 0 0 0 0000 0202 0202 0
00e0 0000 0200 0000 0 0 0 0 0 0 0 0000 0202 0202 0
00a0 0000 0300 9999 5 0 1 1 0 0 0 0000 0000 0202 0
00a0 0000 0300 0000 0 0 0 0 0 0 0 0000 0302 0202 0

// File: verification/decodeStage_tb.sv
// Trace-driven testbench for decodeStage with a reference register model and random writeback tail
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module decodeStage_tb;

   localparam int RANDOM_CYCLES = 40;

   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] imm;
      logic [15:0] pcNow;
      logic [15:0] wbData;
      logic [2:0]  wbAddr;
      logic        lbi;
      logic        link;
      logic        en;
      logic        bFlag;
      logic        jFlag;
      logic        halt;
   } stim_t;

   // Valid bits mark the checked expected columns in the order reg1, reg2, jmp and pcSel
   typedef struct packed {
      logic [3:0]  valid;
      logic [15:0] reg1;
      logic [15:0] reg2;
      logic [15:0] jmp;
      logic        pcSel;
   } expect_t;

   logic clk, rst;
   logic [15:0] instr, imm, pc, pcNow, writeback;
   logic [2:0] writeRegAddr;
   logic lbi, link, en, bFlag, jFlag, halt;
   logic [15:0] reg1Data, reg2Data, jmpData;
   logic pcSel;

   stim_t stimQ[$];
   expect_t expQ[$];
   logic [15:0] model[`REG_COUNT];
   logic mEx, mMem, mWb;
   logic [15:0] mJmp;
   int cycleCount = 0;
   int cycleLimit = 1000;
   integer seed = 32'hc1b4;

   clockGen clockGen_i (.clk(clk), .rst(rst));

   decodeStage dut_i (
      .clk(clk), .rst(rst), .instr(instr), .imm(imm), .pc(pc), .pcNow(pcNow),
      .writeback(writeback), .writeRegAddr(writeRegAddr), .lbi(lbi), .link(link),
      .en(en), .bFlag(bFlag), .jFlag(jFlag), .halt(halt),
      .reg1Data(reg1Data), .reg2Data(reg2Data), .jmpData(jmpData), .pcSel(pcSel)
   );

   task automatic failRun(input string what);
      $display("%s", what);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic compareValue(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   // Turns an expected column into a value and returns whether the column is checked
   // An x entry leaves the column unchecked
   function automatic logic parseExpect(input string s, output logic [15:0] v);
      int n;
      v = '0;
      if (s == "x" || s == "X") return 1'b0;
      n = $sscanf(s, "%h", v);
      return n == 1;
   endfunction

   task automatic readTrace();
      int fd, n;
      string line, e0, e1, e2, e3;
      logic [15:0] f[11];
      stim_t s;
      expect_t e;
      fd = $fopen("verification/decodeStage_trace.txt", "r");
      if (fd == 0) failRun("Could not open the trace file verification/decodeStage_trace.txt");
      while ($fgets(line, fd) != 0) begin
         if (line.len() == 0 || line[0] == "#") continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %s %s %s %s", f[0], f[1], f[2],
                     f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], e0, e1, e2, e3);
         if (n != 15) continue;
         s = '{f[0], f[1], f[2], f[3], f[4][2:0], f[5][0], f[6][0], f[7][0], f[8][0],
               f[9][0], f[10][0]};
         e.valid[3] = parseExpect(e0, e.reg1);
         e.valid[2] = parseExpect(e1, e.reg2);
         e.valid[1] = parseExpect(e2, e.jmp);
         e.valid[0] = parseExpect(e3, f[0]);
         e.pcSel = f[0][0];
         stimQ.push_back(s);
         expQ.push_back(e);
      end
      $fclose(fd);
      if (stimQ.size() == 0) failRun("The trace file holds no stimulus lines");
   endtask

   task automatic applyStim(input stim_t s);
      instr        <= s.instr;
      imm          <= s.imm;
      pcNow        <= s.pcNow;
      writeback    <= s.wbData;
      writeRegAddr <= s.wbAddr;
      lbi          <= s.lbi;
      link         <= s.link;
      en           <= s.en;
      bFlag        <= s.bFlag;
      jFlag        <= s.jFlag;
      halt         <= s.halt;
   endtask

   // Checks one cycle against the model and the optional trace columns, then advances the model
   task automatic checkCycle(input stim_t s, input expect_t e);
      logic jl, take, isJal, wEn;
      logic [2:0] r1Addr, wAddr;
      logic [15:0] wData;
      assert (dut_i.decodeStage_assert_i.failCount == 0)
         else failRun("A concurrent assertion bound to decodeStage failed");
      isJal  = s.instr[15:11] == 5'b00110;
      jl     = isJal || s.instr[15:11] == 5'b00111;
      r1Addr = (isJal && (jl || mEx)) ? 3'd`LINK_REG : s.instr[10:8];
      case (s.instr[12:11])
         2'b00: take = model[r1Addr] == 16'h0;
         2'b01: take = model[r1Addr] != 16'h0;
         2'b10: take = model[r1Addr][15];
         default: take = !model[r1Addr][15];
      endcase
      compareValue("reg1Data", reg1Data, model[r1Addr]);
      compareValue("reg2Data", reg2Data, model[s.instr[7:5]]);
      compareValue("jmpData", jmpData, mJmp);
      compareValue("pcSel", {15'h0, pcSel}, {15'h0,
         ((s.instr[15:13] == 3'b011 || s.bFlag) && !s.halt) ? (take || s.jFlag) : 1'b0});
      if (e.valid[3]) compareValue("reg1Data (trace)", reg1Data, e.reg1);
      if (e.valid[2]) compareValue("reg2Data (trace)", reg2Data, e.reg2);
      if (e.valid[1]) compareValue("jmpData (trace)", jmpData, e.jmp);
      if (e.valid[0]) compareValue("pcSel (trace)", {15'h0, pcSel}, {15'h0, e.pcSel});
      // Link writes win the port and writeback waits while a link is downstream
      wEn   = jl || (s.en && !(mEx || mMem || mWb));
      wAddr = jl ? 3'd`LINK_REG : s.wbAddr;
      wData = (s.link || jl || mEx) ? s.pcNow + 16'd2 : (s.lbi ? s.imm : s.wbData);
      if (wEn) model[wAddr] = wData;
      if (jl) mJmp = wData;
      mWb  = mMem;
      mMem = mEx;
      mEx  = jl;
   endtask

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > cycleLimit) failRun("Timeout, the run exceeded its cycle limit");
   end

   initial begin
      stim_t s;
      expect_t noExp;
      logic [31:0] r;
      instr <= '0;
      imm <= '0;
      pc <= '0;
      pcNow <= '0;
      writeback <= '0;
      writeRegAddr <= '0;
      lbi <= 1'b0;
      link <= 1'b0;
      en <= 1'b0;
      bFlag <= 1'b0;
      jFlag <= 1'b0;
      halt <= 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
      mEx = 1'b0;
      mMem = 1'b0;
      mWb = 1'b0;
      mJmp = '0;
      noExp = '0;
      readTrace();
      cycleLimit = stimQ.size() + RANDOM_CYCLES + 10;
      @(negedge rst);
      foreach (stimQ[i]) begin
         @(posedge clk);
         applyStim(stimQ[i]);
         @(negedge clk);
         checkCycle(stimQ[i], expQ[i]);
      end
      // Random tail mixing branches, links and writebacks with expectations from the model alone
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         s = '0;
         r = $random(seed);
         s.instr = {1'b0, r[15:12], r[2:0], r[5:3], 5'b0};
         s.en = r[6];
         s.lbi = r[7];
         s.wbAddr = r[10:8];
         s.bFlag = r[16];
         s.jFlag = r[17];
         s.halt = r[18] & r[19];
         s.link = r[20] & r[21];
         s.pcNow = {r[31:22], 6'b0};
         r = $random(seed);
         s.wbData = r[15:0];
         s.imm = r[31:16];
         @(posedge clk);
         applyStim(s);
         @(negedge clk);
         checkCycle(s, noExp);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/decodeStage_assert.sv
// Concurrent checks on halt gating and link write arbitration, bound into every decodeStage
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module decodeStage_assert (
   input wire logic                   clk,
   input wire logic                   rst,
   input wire logic                   halt,
   input wire logic                   pcSel,
   input wire logic                   jlNow,
   input wire logic                   writeEn,
   input wire logic [`DATA_WIDTH-1:0] pcNow,
   input wire logic [`DATA_WIDTH-1:0] linkReg
);

   // Running count of failed properties so the testbench can see them
   int failCount = 0;

   // A halted pipeline never redirects fetch
   haltBlocksPcSel: assert property (@(posedge clk) disable iff (rst) halt |-> !pcSel)
      else begin
         failCount++;
         $error("pcSel high while halt is set");
      end

   // In the three cycles behind a jump-and-link only another link may write
   noWritebackInFlight: assert property (@(posedge clk) disable iff (rst)
      jlNow |=> (!writeEn || jlNow) [*3])
      else begin
         failCount++;
         $error("writeback reached the register file while a link was in flight");
      end

   // One cycle after a jump-and-link the link register holds its return address
   linkWriteLands: assert property (@(posedge clk) disable iff (rst)
      jlNow |=> (linkReg == $past(pcNow) + `DATA_WIDTH'(2)))
      else begin
         failCount++;
         $error("jump-and-link did not leave its return address in the link register");
      end

endmodule

bind decodeStage decodeStage_assert decodeStage_assert_i (
   .clk      (clk),
   .rst      (rst),
   .halt     (halt),
   .pcSel    (pcSel),
   .jlNow    (linkTracker_i.jlNow),
   .writeEn  (regWrite.en),
   .pcNow    (pcNow),
   .linkReg  (regFile_i.regs[`LINK_REG])
);

`default_nettype wire

// File: verification/clockGen.sv
// Testbench clock and reset source, 20 ns period with reset held for two cycles
`default_nettype none
`timescale 1ns/1ps

module clockGen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

   // Reset drops on the edge that ends the last reset cycle
   initial begin
      rst <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
// Decode stage top that splits the instruction and wires the link tracker, register file and branch logic
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module decodeStage (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`DATA_WIDTH-1:0] instr,
   input  logic [`DATA_WIDTH-1:0] imm,
   input  logic [`DATA_WIDTH-1:0] pc,
   input  logic [`DATA_WIDTH-1:0] pcNow,
   input  logic [`DATA_WIDTH-1:0] writeback,
   input  logic [`REG_ADDR_W-1:0] writeRegAddr,
   input  logic                   lbi,
   input  logic                   link,
   input  logic                   en,
   input  logic                   bFlag,
   input  logic                   jFlag,
   input  logic                   halt,
   output logic [`DATA_WIDTH-1:0] reg1Data,
   output logic [`DATA_WIDTH-1:0] reg2Data,
   output logic [`DATA_WIDTH-1:0] jmpData,
   output logic                   pcSel
);

   // The pc port stays for compatibility with the full pipeline and has no load here

   logic [4:0]             opcode;
   logic [`REG_ADDR_W-1:0] rs;
   logic [`REG_ADDR_W-1:0] rt;
   logic [`REG_ADDR_W-1:0] readAddr1;
   logic                   read1Link;
   logic                   isBranch;
   decode_pkg::wbIn_t      wbIn;
   decode_pkg::regWrite_t  regWrite;

   // Instruction fields
   assign opcode = instr[15:11];
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];

   // Branch opcodes share the top three bits
   assign isBranch = (instr[15:13] == decode_pkg::OP_BRANCH_PREFIX);

   // JAL redirects read port 1 to the link register
   assign readAddr1 = read1Link ? `REG_ADDR_W'(`LINK_REG) : rs;

   // Writeback request bundled for the tracker
   assign wbIn = '{en: en, addr: writeRegAddr, data: writeback, imm: imm, lbi: lbi};

   linkTracker linkTracker_i (
      .clk      (clk),
      .rst      (rst),
      .opcode   (opcode),
      .pcNow    (pcNow),
      .link     (link),
      .wb       (wbIn),
      .write    (regWrite),
      .read1Link(read1Link),
      .jmpData  (jmpData)
   );

   regFile regFile_i (
      .clk      (clk),
      .rst      (rst),
      .readAddr1(readAddr1),
      .readAddr2(rt),
      .write    (regWrite),
      .readData1(reg1Data),
      .readData2(reg2Data)
   );

   // Condition code sits in the low two opcode bits
   branchResolve branchResolve_i (
      .operand (reg1Data),
      .cond    (instr[12:11]),
      .isBranch(isBranch),
      .bFlag   (bFlag),
      .jFlag   (jFlag),
      .halt    (halt),
      .pcSel   (pcSel)
   );

endmodule

`default_nettype wire

// File: hdl/linkTracker.sv
// Jump-and-link tracker that writes the return address early and arbitrates register file writes
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module linkTracker (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [4:0]             opcode,
   input  logic [`DATA_WIDTH-1:0] pcNow,
   input  logic                   link,
   input  decode_pkg::wbIn_t      wb,
   output decode_pkg::regWrite_t  write,
   output logic                   read1Link,
   output logic [`DATA_WIDTH-1:0] jmpData
);

   logic                   jlNow;
   logic                   exJl;
   logic                   memJl;
   logic                   wbJl;
   logic                   inFlight;
   logic [`DATA_WIDTH-1:0] pcPlus2;
   logic [`DATA_WIDTH-1:0] immSel;

   // JAL and JALR both link through the same path
   assign jlNow = (opcode == decode_pkg::OP_JAL) || (opcode == decode_pkg::OP_JALR);

   // Follows each jump-and-link slot through execute, memory and writeback
   // Several can be in flight at once since each stage has its own flop
   always_ff @(posedge clk) begin
      if (rst) begin
         exJl  <= 1'b0;
         memJl <= 1'b0;
         wbJl  <= 1'b0;
      end else begin
         exJl  <= jlNow;
         memJl <= exJl;
         wbJl  <= memJl;
      end
   end

   // While a linked slot is downstream its own writeback must not land again
   assign inFlight = exJl | memJl | wbJl;

   // Return address is the instruction after the one being decoded
   assign pcPlus2 = pcNow + `DATA_WIDTH'(2);

   // LBI loads the immediate straight into the destination
   assign immSel = wb.lbi ? wb.imm : wb.data;

   // The jump-and-link write takes the port as soon as it is decoded
   // Ordinary writebacks wait until no linked slot is in the later stages
   always_comb begin
      write.data = (link | jlNow | exJl) ? pcPlus2 : immSel;
      write.addr = jlNow ? `REG_ADDR_W'(`LINK_REG) : wb.addr;
      write.en   = jlNow | (wb.en & ~inFlight);
   end

   // JAL reads its target from the link register while the write settles
   assign read1Link = (opcode == decode_pkg::OP_JAL) & (jlNow | exJl);

   // Last link value kept for fetch as a jump target
   always_ff @(posedge clk) begin
      if (rst) begin
         jmpData <= '0;
      end else if (jlNow) begin
         jmpData <= write.data;
      end
   end

endmodule

`default_nettype wire

// File: hdl/branchResolve.sv
// Branch resolution against zero on the first read operand, producing the fetch PC select
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module branchResolve (
   input  logic [`DATA_WIDTH-1:0] operand,
   input  logic [1:0]             cond,
   input  logic                   isBranch,
   input  logic                   bFlag,
   input  logic                   jFlag,
   input  logic                   halt,
   output logic                   pcSel
);

   logic zero;
   logic negative;
   logic take;

   // Flags on the register being tested
   assign zero = (operand == '0);

   // Two's complement sign bit marks a negative value
   assign negative = operand[`DATA_WIDTH-1];

   // The condition field chooses which flag decides the branch
   always_comb begin
      unique case (cond)
         decode_pkg::COND_EQZ: take = zero;
         decode_pkg::COND_NEZ: take = ~zero;
         decode_pkg::COND_LTZ: take = negative;
         decode_pkg::COND_GEZ: take = ~negative;
      endcase
   end

   // A redirect only happens for branch or jump instructions
   // Unconditional jumps force the select through jFlag
   // A halted pipeline never redirects fetch
   assign pcSel = ((isBranch | bFlag) & ~halt) ? (take | jFlag) : 1'b0;

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// Eight-entry register file with two combinational read ports and one clocked write port
`default_nettype none
`timescale 1ns/1ps

`include "decode_defines.svh"

module regFile (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`REG_ADDR_W-1:0] readAddr1,
   input  logic [`REG_ADDR_W-1:0] readAddr2,
   input  decode_pkg::regWrite_t  write,
   output logic [`DATA_WIDTH-1:0] readData1,
   output logic [`DATA_WIDTH-1:0] readData2
);

   // Register storage indexed by register number
   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   // All registers clear together on reset
   // Outside reset at most one entry changes per cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (write.en) begin
         regs[write.addr] <= write.data;
      end
   end

   // Reads see the array as it stands this cycle
   // A value written at an edge is only visible after that edge
   // There is no write-to-read bypass
   assign readData1 = regs[readAddr1];
   assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

// File: hdl/decode_pkg.sv
// Opcode constants and the packed structs that travel between the decode-stage blocks
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

   // Jump-and-link opcodes in instruction bits 15 to 11
   localparam logic [4:0] OP_JAL = 5'b00110;
   localparam logic [4:0] OP_JALR = 5'b00111;

   // Any opcode whose top three bits match this is a conditional branch
   localparam logic [2:0] OP_BRANCH_PREFIX = 3'b011;

   // Branch condition codes carried in instruction bits 12 to 11
   localparam logic [1:0] COND_EQZ = 2'b00;
   localparam logic [1:0] COND_NEZ = 2'b01;
   localparam logic [1:0] COND_LTZ = 2'b10;
   localparam logic [1:0] COND_GEZ = 2'b11;

   // One register file write as chosen by the link tracker
   // Field order puts the enable in the top bit
   typedef struct packed {
      logic                   en;
      logic [`REG_ADDR_W-1:0] addr;
      logic [`DATA_WIDTH-1:0] data;
   } regWrite_t;

   // Writeback request arriving from later pipeline stages
   // The immediate and LBI select ride along so the tracker can pick the data itself
   typedef struct packed {
      logic                   en;
      logic [`REG_ADDR_W-1:0] addr;
      logic [`DATA_WIDTH-1:0] data;
      logic [`DATA_WIDTH-1:0] imm;
      logic                   lbi;
   } wbIn_t;

endpackage

`default_nettype wire

// File: hdl/decode_defines.svh
// Width and register-index macros for the decode stage, included by the package and every RTL block
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Machine word size for registers, PC and immediates
`define DATA_WIDTH 16

// The register file holds eight general registers
`define REG_COUNT 8

// Bits needed to name one of the registers
`define REG_ADDR_W 3

// Jump-and-link always deposits its return address here
`define LINK_REG 7

`endif
